// File: verilog/raycast_pkg.sv
package raycast_pkg;

    // fixed-point widths
    localparam int COORD_W = 12;
    localparam int RSQ_W   = 24;
    localparam int DOT_W   = 28;
    localparam int DISC_W  = 64;

    // scene size
    localparam int NUM_SHAPES = 8;
    localparam int IDX_W      = 3;

    // host bus
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // sphere table window, four words per entry
    localparam logic [ADDR_W-1:0] SHAPE_BASE = 12'h100;
    localparam int SHAPE_STRIDE = 16;

    // request to response latency of the sphere test
    localparam int SPHERE_LAT = 3;

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic signed [COORD_W-1:0] z;
    } vec3_t;

    typedef struct packed {
        vec3_t src;
        vec3_t dir;
    } ray_t;

    typedef struct packed {
        vec3_t             center;
        logic [RSQ_W-1:0]  radius_sq;
    } sphere_t;

    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] idx;
        sphere_t          sphere;
    } probe_req_t;

    typedef struct packed {
        logic                    valid;
        logic [IDX_W-1:0]        idx;
        logic                    hit;
        logic signed [DOT_W-1:0] key;
    } probe_rsp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // register map below the sphere table
    typedef enum logic [ADDR_W-1:0] {
        CTRL   = 12'h000,
        STATUS = 12'h004,
        SRC_X  = 12'h008,
        SRC_Y  = 12'h00C,
        SRC_Z  = 12'h010,
        DIR_X  = 12'h014,
        DIR_Y  = 12'h018,
        DIR_Z  = 12'h01C,
        RESULT = 12'h020,
        KEY    = 12'h024
    } reg_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        SENDING,
        DRAINING
    } sweep_state_e;

endpackage

// File: verilog/apb_scene_regs.sv
module apb_scene_regs
    import raycast_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    input  logic                    busy,
    input  logic                    done,
    input  logic [IDX_W-1:0]        shape_idx,
    output sphere_t                 sphere,
    output ray_t                    ray,
    output logic                    start,
    input  logic                    best_hit,
    input  logic [IDX_W-1:0]        best_idx,
    input  logic signed [DOT_W-1:0] best_key
);

    sphere_t shapes [NUM_SHAPES];

    reg_sel_e          sel;
    logic              access;
    logic              reg_hit;
    logic              tbl_hit;
    logic              slv_err;
    logic              wr_ok;
    logic              done_flag;
    logic              pready_q;
    logic [ADDR_W-1:0] tbl_off;
    logic [IDX_W-1:0]  tbl_idx;
    logic [1:0]        tbl_word;
    sphere_t           tbl_entry;
    logic [DATA_W-1:0] reg_rdata;
    logic [DATA_W-1:0] tbl_rdata;

    assign access = apb_req.psel && apb_req.penable;
    assign sel    = reg_sel_e'(apb_req.paddr);

    // sphere table slot decode, word aligned only
    assign tbl_off  = apb_req.paddr - SHAPE_BASE;
    assign tbl_hit  = (apb_req.paddr >= SHAPE_BASE)
                   && (tbl_off < ADDR_W'(NUM_SHAPES * SHAPE_STRIDE))
                   && (apb_req.paddr[1:0] == 2'b00);
    assign tbl_idx  = IDX_W'(tbl_off / SHAPE_STRIDE);
    assign tbl_word = tbl_off[3:2];

    // the sequencer looks up its own slot
    assign sphere    = shapes[shape_idx];
    assign tbl_entry = shapes[tbl_idx];

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (sel)
            CTRL:    reg_rdata = '0;
            STATUS:  reg_rdata = DATA_W'({done_flag, busy});
            SRC_X:   reg_rdata = DATA_W'(ray.src.x);
            SRC_Y:   reg_rdata = DATA_W'(ray.src.y);
            SRC_Z:   reg_rdata = DATA_W'(ray.src.z);
            DIR_X:   reg_rdata = DATA_W'(ray.dir.x);
            DIR_Y:   reg_rdata = DATA_W'(ray.dir.y);
            DIR_Z:   reg_rdata = DATA_W'(ray.dir.z);
            RESULT:  reg_rdata = DATA_W'({best_idx, 3'b000, best_hit});
            KEY:     reg_rdata = DATA_W'(best_key);
            default: reg_hit   = 1'b0;
        endcase
    end

    always_comb begin
        case (tbl_word)
            2'd0:    tbl_rdata = DATA_W'(tbl_entry.center.x);
            2'd1:    tbl_rdata = DATA_W'(tbl_entry.center.y);
            2'd2:    tbl_rdata = DATA_W'(tbl_entry.center.z);
            default: tbl_rdata = DATA_W'(tbl_entry.radius_sq);
        endcase
    end

    // only STATUS may be touched while a sweep runs
    assign slv_err = access
                  && (!(reg_hit || tbl_hit) || (apb_req.pwrite && busy && sel != STATUS));
    assign wr_ok   = access && apb_req.pwrite && !slv_err;

    assign apb_rsp.pready  = pready_q;
    assign apb_rsp.pslverr = slv_err;
    assign apb_rsp.prdata  = !access ? '0 : reg_hit ? reg_rdata : tbl_hit ? tbl_rdata : '0;

    // scene storage
    always_ff @(posedge clk) begin
        if (wr_ok && reg_hit) begin
            case (sel)
                SRC_X:   ray.src.x <= apb_req.pwdata[COORD_W-1:0];
                SRC_Y:   ray.src.y <= apb_req.pwdata[COORD_W-1:0];
                SRC_Z:   ray.src.z <= apb_req.pwdata[COORD_W-1:0];
                DIR_X:   ray.dir.x <= apb_req.pwdata[COORD_W-1:0];
                DIR_Y:   ray.dir.y <= apb_req.pwdata[COORD_W-1:0];
                DIR_Z:   ray.dir.z <= apb_req.pwdata[COORD_W-1:0];
                default: ;
            endcase
        end
        if (wr_ok && tbl_hit) begin
            case (tbl_word)
                2'd0:    shapes[tbl_idx].center.x  <= apb_req.pwdata[COORD_W-1:0];
                2'd1:    shapes[tbl_idx].center.y  <= apb_req.pwdata[COORD_W-1:0];
                2'd2:    shapes[tbl_idx].center.z  <= apb_req.pwdata[COORD_W-1:0];
                default: shapes[tbl_idx].radius_sq <= apb_req.pwdata[RSQ_W-1:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pready_q  <= 1'b0;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            // ready follows a setup phase, so no wait states
            pready_q <= apb_req.psel && !apb_req.penable;
            start    <= wr_ok && reg_hit && (sel == CTRL) && apb_req.pwdata[0];
            if (start) begin
                done_flag <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
            end
        end
    end

    a_pready_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else $error("apb_scene_regs: pready outside access phase");

endmodule

// File: verilog/sweep_ctrl.sv
module sweep_ctrl
    import raycast_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  sphere_t          sphere,
    input  logic             rsp_valid,
    output logic [IDX_W-1:0] shape_idx,
    output probe_req_t       req,
    output logic             busy,
    output logic             done
);

    sweep_state_e   state;
    logic [IDX_W:0] rsp_cnt;
    logic           last_sent;
    logic           last_rsp;
    logic           issue;

    // final index sitting in the request register ends the issue phase
    assign last_sent = req.valid && (req.idx == IDX_W'(NUM_SHAPES - 1));
    assign last_rsp  = rsp_valid && (rsp_cnt == (IDX_W + 1)'(NUM_SHAPES - 1));

    // first sphere goes out together with the start pulse
    assign issue = ((state == IDLE) && start) || ((state == SENDING) && !last_sent);
    assign busy  = (state != IDLE);

    always_ff @(posedge clk) begin
        req.idx    <= shape_idx;
        req.sphere <= sphere;
        if (rst) begin
            state     <= IDLE;
            shape_idx <= '0;
            rsp_cnt   <= '0;
            req.valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            done      <= 1'b0;
            req.valid <= issue;
            if (issue) begin
                shape_idx <= shape_idx + 1'b1;
            end
            if (rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= SENDING;
                        rsp_cnt <= '0;
                    end
                end
                SENDING: begin
                    if (last_sent) begin
                        state     <= DRAINING;
                        shape_idx <= '0;
                    end
                end
                DRAINING: begin
                    // busy drops in the same cycle as done
                    if (last_rsp) begin
                        state   <= IDLE;
                        done    <= 1'b1;
                        rsp_cnt <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_req_in_sending: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> (state == SENDING))
        else $error("sweep_ctrl: request valid outside SENDING");

endmodule

// File: verilog/sphere_test.sv
module sphere_test
    import raycast_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ray_t       ray,
    input  probe_req_t req,
    output probe_rsp_t rsp
);

    // stage 1, origin relative to the centre
    logic                    s1_valid;
    logic [IDX_W-1:0]        s1_idx;
    logic signed [COORD_W:0] s1_oc_x;
    logic signed [COORD_W:0] s1_oc_y;
    logic signed [COORD_W:0] s1_oc_z;
    logic signed [RSQ_W:0]   s1_rsq;

    // stage 2, dot products
    logic                    s2_valid;
    logic [IDX_W-1:0]        s2_idx;
    logic signed [DOT_W-1:0] s2_b;
    logic signed [DOT_W-1:0] s2_c;
    logic signed [DOT_W-1:0] s2_a;

    logic signed [DISC_W-1:0] disc;

    // quarter discriminant of the ray quadratic
    assign disc = s2_b * s2_b - s2_a * s2_c;

    always_ff @(posedge clk) begin
        s1_idx  <= req.idx;
        s1_oc_x <= ray.src.x - req.sphere.center.x;
        s1_oc_y <= ray.src.y - req.sphere.center.y;
        s1_oc_z <= ray.src.z - req.sphere.center.z;
        s1_rsq  <= $signed({1'b0, req.sphere.radius_sq});

        s2_idx <= s1_idx;
        s2_b   <= s1_oc_x * ray.dir.x + s1_oc_y * ray.dir.y + s1_oc_z * ray.dir.z;
        s2_c   <= s1_oc_x * s1_oc_x + s1_oc_y * s1_oc_y + s1_oc_z * s1_oc_z - s1_rsq;
        // same for every sphere of a sweep
        s2_a   <= ray.dir.x * ray.dir.x + ray.dir.y * ray.dir.y + ray.dir.z * ray.dir.z;

        rsp.idx <= s2_idx;
        // negative b keeps spheres behind the origin out
        rsp.hit <= (disc >= 0) && (s2_b < 0);
        rsp.key <= -s2_b;

        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp.valid <= 1'b0;
        end else begin
            s1_valid  <= req.valid;
            s2_valid  <= s1_valid;
            rsp.valid <= s2_valid;
        end
    end

    a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        rsp.valid == $past(req.valid, SPHERE_LAT))
        else $error("sphere_test: response valid out of step with request");

endmodule

// File: verilog/nearest_hit.sv
module nearest_hit
    import raycast_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  probe_rsp_t              rsp,
    output logic                    best_hit,
    output logic [IDX_W-1:0]        best_idx,
    output logic signed [DOT_W-1:0] best_key
);

    logic take;

    // strict compare so the earlier, lower index wins a tie
    assign take = rsp.valid && rsp.hit && (!best_hit || (rsp.key < best_key));

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            best_hit <= 1'b0;
            best_idx <= '0;
            best_key <= '0;
        end else if (take) begin
            best_hit <= 1'b1;
            best_idx <= rsp.idx;
            best_key <= rsp.key;
        end
    end

    // only spheres ahead of the origin can be kept
    a_key_positive: assert property (@(posedge clk) disable iff (rst)
        best_hit |-> (best_key > 0))
        else $error("nearest_hit: best key not positive");

endmodule

// File: verilog/raycast_top.sv
module raycast_top
    import raycast_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // sweep control
    logic start;
    logic busy;
    logic done;

    // sphere fetch and probe path
    logic [IDX_W-1:0] shape_idx;
    sphere_t          sphere;
    ray_t             ray;
    probe_req_t       req;
    probe_rsp_t       rsp;

    // nearest hit so far
    logic                    best_hit;
    logic [IDX_W-1:0]        best_idx;
    logic signed [DOT_W-1:0] best_key;

    apb_scene_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .busy      (busy),
        .done      (done),
        .shape_idx (shape_idx),
        .sphere    (sphere),
        .ray       (ray),
        .start     (start),
        .best_hit  (best_hit),
        .best_idx  (best_idx),
        .best_key  (best_key)
    );

    sweep_ctrl u_sweep (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .sphere    (sphere),
        .rsp_valid (rsp.valid),
        .shape_idx (shape_idx),
        .req       (req),
        .busy      (busy),
        .done      (done)
    );

    sphere_test u_sphere (
        .clk (clk),
        .rst (rst),
        .ray (ray),
        .req (req),
        .rsp (rsp)
    );

    nearest_hit u_nearest (
        .clk      (clk),
        .rst      (rst),
        .clear    (start),
        .rsp      (rsp),
        .best_hit (best_hit),
        .best_idx (best_idx),
        .best_key (best_key)
    );

endmodule

// File: testbench/tb_checker.sv
module tb_checker
    import raycast_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp
);

    typedef struct {
        bit                wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] mask;
        bit                err;
    } xfer_t;

    xfer_t pending_q [$];

    int data_errs  = 0;
    int proto_errs = 0;

    // scene copy for the reference model
    longint m_src [3];
    longint m_dir [3];
    longint m_ctr [NUM_SHAPES][3];
    longint m_rsq [NUM_SHAPES];

    task automatic expect_xfer(bit wr, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                               logic [DATA_W-1:0] mask, bit err);
        xfer_t x;
        x.wr   = wr;
        x.addr = addr;
        x.data = data;
        x.mask = mask;
        x.err  = err;
        pending_q.push_back(x);
    endtask

    task automatic model_ray(int sx, int sy, int sz, int dx, int dy, int dz);
        m_src = '{longint'(sx), longint'(sy), longint'(sz)};
        m_dir = '{longint'(dx), longint'(dy), longint'(dz)};
    endtask

    task automatic model_sphere(int i, int cx, int cy, int cz, int rsq);
        m_ctr[i] = '{longint'(cx), longint'(cy), longint'(cz)};
        m_rsq[i] = longint'(rsq);
    endtask

    // nearest hit by the projection key, lower index on a tie
    task automatic model_eval(output bit hit, output int idx, output int key);
        longint oc;
        longint a;
        longint b;
        longint c;
        hit = 1'b0;
        idx = 0;
        key = 0;
        a   = m_dir[0] * m_dir[0] + m_dir[1] * m_dir[1] + m_dir[2] * m_dir[2];
        for (int i = 0; i < NUM_SHAPES; i++) begin
            b = 0;
            c = -m_rsq[i];
            for (int k = 0; k < 3; k++) begin
                oc = m_src[k] - m_ctr[i][k];
                b  = b + oc * m_dir[k];
                c  = c + oc * oc;
            end
            if (b * b - a * c >= 0 && b < 0 && (!hit || -b < longint'(key))) begin
                hit = 1'b1;
                idx = i;
                key = int'(-b);
            end
        end
    endtask

    task automatic flush_check();
        if (pending_q.size() != 0) begin
            $display("%0d expected APB transfers never happened", pending_q.size());
            proto_errs += pending_q.size();
        end
    endtask

    // access phase values are settled by the falling edge
    always @(negedge clk) begin : monitor
        xfer_t x;
        if (!rst && apb_req.psel && apb_req.penable) begin
            if (pending_q.size() == 0) begin
                $display("unexpected APB transfer at address %h", apb_req.paddr);
                proto_errs++;
            end else begin
                x = pending_q.pop_front();
                if (apb_req.pwrite !== x.wr) begin
                    $display("FAIL pwrite @%h: expected %h got %h",
                             x.addr, x.wr, apb_req.pwrite);
                    proto_errs++;
                end
                if (apb_req.paddr !== x.addr) begin
                    $display("FAIL paddr: expected %h got %h", x.addr, apb_req.paddr);
                    proto_errs++;
                end
                if (apb_rsp.pready !== 1'b1) begin
                    $display("FAIL pready @%h: expected 1 got %h", x.addr, apb_rsp.pready);
                    proto_errs++;
                end
                if (apb_rsp.pslverr !== x.err) begin
                    $display("FAIL pslverr @%h: expected %h got %h",
                             x.addr, x.err, apb_rsp.pslverr);
                    data_errs++;
                end
                if (!x.wr && ((apb_rsp.prdata & x.mask) !== (x.data & x.mask))) begin
                    $display("FAIL prdata @%h: expected %h got %h",
                             x.addr, x.data & x.mask, apb_rsp.prdata & x.mask);
                    data_errs++;
                end
            end
        end
    end

endmodule

// File: testbench/tb_top.sv
module tb_top
    import raycast_pkg::*;
();

    localparam int FIXED_ROWS  = 3;
    localparam int NUM_ROWS    = 8;
    // APB transfers per row, polls included
    localparam int ACC_PER_ROW = 140;
    localparam int TIMEOUT     = NUM_ROWS * (ACC_PER_ROW + 20) * 8 * 4;

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int seed = 32'h54d8;
    int errors_seq;
    int total;

    // scenario table: ray, spheres and the expected nearest hit
    int ray_tab [NUM_ROWS][6];
    int sph_tab [NUM_ROWS][NUM_SHAPES][4];
    bit exp_hit [NUM_ROWS];
    int exp_idx [NUM_ROWS];
    int exp_key [NUM_ROWS];

    always #4 clk = ~clk;

    raycast_top dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    tb_checker chk (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [ADDR_W-1:0] shape_addr(int i, int w);
        return SHAPE_BASE + ADDR_W'(i * SHAPE_STRIDE + w * 4);
    endfunction

    function automatic logic [ADDR_W-1:0] ray_addr(int k);
        return ADDR_W'(int'(SRC_X) + 4 * k);
    endfunction

    // RESULT word of a row: hit in bit 0, index in bits 6:4
    function automatic logic [DATA_W-1:0] result_word(int r);
        return {25'b0, 3'(exp_idx[r]), 3'b000, exp_hit[r]};
    endfunction

    // index only means something on a hit
    function automatic logic [DATA_W-1:0] result_mask(int r);
        return exp_hit[r] ? 32'h71 : 32'h1;
    endfunction

    task automatic set_ray(int r, int sx, int sy, int sz, int dx, int dy, int dz);
        ray_tab[r] = '{sx, sy, sz, dx, dy, dz};
    endtask

    task automatic set_sphere(int r, int i, int cx, int cy, int cz, int rsq);
        sph_tab[r][i] = '{cx, cy, cz, rsq};
    endtask

    task automatic set_expect(int r, bit hit, int idx, int key);
        exp_hit[r] = hit;
        exp_idx[r] = idx;
        exp_key[r] = key;
    endtask

    task automatic fill_rows();
        int t;
        for (int r = 0; r < FIXED_ROWS; r++) begin
            for (int i = 0; i < NUM_SHAPES; i++) begin
                // off to the side, b = 0, never a hit
                set_sphere(r, i, 0, 1000, 0, 1);
            end
        end
        // several spheres on the x axis, one behind, one off axis
        set_ray(0, 0, 0, 0, 1, 0, 0);
        set_sphere(0, 0, 300, 0, 0, 100);
        set_sphere(0, 1, 120, 0, 0, 100);
        set_sphere(0, 2, 50, 0, 0, 100);
        set_sphere(0, 3, -20, 0, 0, 100);
        set_sphere(0, 4, 100, 500, 0, 100);
        set_expect(0, 1'b1, 2, 50);
        // all miss or behind
        set_ray(1, 0, 0, 0, 1, 0, 0);
        set_sphere(1, 1, -100, 0, 0, 400);
        set_sphere(1, 5, 100, 500, 0, 100);
        set_sphere(1, 7, -300, -2, 0, 900);
        set_expect(1, 1'b0, 0, 0);
        // equal keys at index 3 and 5
        set_ray(2, 10, 0, 0, 1, 0, 0);
        set_sphere(2, 3, 80, 5, 0, 100);
        set_sphere(2, 5, 80, -5, 0, 100);
        set_sphere(2, 6, 200, 0, 0, 100);
        set_expect(2, 1'b1, 3, 70);
        for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
            set_ray(r, rand_range(-200, 200), rand_range(-200, 200), rand_range(-200, 200),
                    rand_range(1, 16), rand_range(-16, 16), rand_range(-16, 16));
            chk.model_ray(ray_tab[r][0], ray_tab[r][1], ray_tab[r][2],
                          ray_tab[r][3], ray_tab[r][4], ray_tab[r][5]);
            for (int i = 0; i < NUM_SHAPES; i++) begin
                // centres scattered along the ray, some behind the origin
                t = rand_range(-5, 20);
                for (int k = 0; k < 3; k++) begin
                    sph_tab[r][i][k] = ray_tab[r][k] + t * ray_tab[r][3+k] + rand_range(-30, 30);
                end
                sph_tab[r][i][3] = rand_range(0, 4000);
                chk.model_sphere(i, sph_tab[r][i][0], sph_tab[r][i][1], sph_tab[r][i][2],
                                 sph_tab[r][i][3]);
            end
            chk.model_eval(exp_hit[r], exp_idx[r], exp_key[r]);
        end
    endtask

    task automatic apb_xfer(input bit wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp_data,
                            input logic [DATA_W-1:0] mask, input bit exp_err,
                            output logic [DATA_W-1:0] rdata);
        chk.expect_xfer(wr, addr, exp_data, mask, exp_err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data, bit err);
        logic [DATA_W-1:0] rd;
        apb_xfer(1'b1, addr, data, '0, '0, err, rd);
    endtask

    task automatic read_check(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                              logic [DATA_W-1:0] mask, bit err);
        logic [DATA_W-1:0] rd;
        apb_xfer(1'b0, addr, '0, data, mask, err, rd);
    endtask

    task automatic run_row(int r);
        logic [DATA_W-1:0] rd;
        int polls;
        for (int k = 0; k < 6; k++) begin
            write_reg(ray_addr(k), ray_tab[r][k], 1'b0);
        end
        for (int i = 0; i < NUM_SHAPES; i++) begin
            for (int w = 0; w < 4; w++) begin
                write_reg(shape_addr(i, w), sph_tab[r][i][w], 1'b0);
            end
        end
        // read-only registers take the write silently and keep their value
        write_reg(RESULT, '1, 1'b0);
        write_reg(STATUS, '1, 1'b0);
        if (r == 0) begin
            read_check(RESULT, '0, 32'h1, 1'b0);
            read_check(STATUS, '0, '1, 1'b0);
        end else begin
            read_check(RESULT, result_word(r - 1), result_mask(r - 1), 1'b0);
            read_check(STATUS, 32'h2, '1, 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            read_check(ray_addr(k), ray_tab[r][k], '1, 1'b0);
        end
        for (int i = 0; i < NUM_SHAPES; i++) begin
            for (int w = 0; w < 4; w++) begin
                read_check(shape_addr(i, w), sph_tab[r][i][w], '1, 1'b0);
            end
        end
        write_reg(CTRL, 32'h1, 1'b0);
        // scene is locked during the sweep
        write_reg(SRC_X, ray_tab[r][0] + 1, 1'b1);
        write_reg(shape_addr(0, 0), sph_tab[r][0][0] + 1, 1'b1);
        read_check(12'h080, '0, '0, 1'b1);
        polls = 0;
        rd = '0;
        while (!rd[1] && polls < 40) begin
            apb_xfer(1'b0, STATUS, '0, '0, '0, 1'b0, rd);
            polls++;
        end
        if (!rd[1]) begin
            $display("row %0d: STATUS.done never came up", r);
            errors_seq++;
        end
        read_check(SRC_X, ray_tab[r][0], '1, 1'b0);
        read_check(shape_addr(0, 0), sph_tab[r][0][0], '1, 1'b0);
        read_check(STATUS, 32'h2, '1, 1'b0);
        read_check(RESULT, result_word(r), result_mask(r), 1'b0);
        read_check(KEY, exp_key[r], exp_hit[r] ? '1 : '0, 1'b0);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish in %0d time units", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        apb_req    = '0;
        errors_seq = 0;
        fill_rows();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        repeat (4) @(posedge clk);
        chk.flush_check();
        total = chk.data_errs + chk.proto_errs + errors_seq;
        $display("errors: data %0d protocol %0d sequence %0d",
                 chk.data_errs, chk.proto_errs, errors_seq);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/raycast_pkg.sv
verilog/apb_scene_regs.sv
verilog/sweep_ctrl.sv
verilog/sphere_test.sv
verilog/nearest_hit.sv
verilog/raycast_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run; pass only if the pass line shows up
verilator --binary --assert --top-module tb_top -f src.f -o tb_sim \
    && ./obj_dir/tb_sim | grep "TEST RESULT: PASS" \
    || exit 1
